// File: verilog/if_pkg.sv
package if_pkg;

   // instruction and program memory geometry
   localparam int INSTR_WIDTH = 32;
   localparam int ADDR_WIDTH  = 11;        // word address, 2k words
   localparam int MEM_DEPTH   = 2048;

   // instruction queue between fetch and issue
   localparam int QUEUE_DEPTH = 4;
   localparam int COUNT_WIDTH = 3;         // holds 0..QUEUE_DEPTH

   // one fetched word with the address it came from
   typedef struct packed {
      logic [ADDR_WIDTH-1:0]  pc;          // address tag
      logic [INSTR_WIDTH-1:0] instr;       // raw instruction word
   } fetch_word_t;

endpackage

// File: verilog/program_memory.sv
`timescale 1ns/1ps

module program_memory
   (
      input  logic                          i_clock,

      input  logic                          i_wr_en,
      input  logic [if_pkg::ADDR_WIDTH-1:0]  i_wr_addr,
      input  logic [if_pkg::INSTR_WIDTH-1:0] i_wr_data,

      input  logic                          i_rd_en,
      input  logic [if_pkg::ADDR_WIDTH-1:0]  i_rd_addr,
      output logic [if_pkg::INSTR_WIDTH-1:0] o_rd_data
   );

   import if_pkg::*;

   logic [INSTR_WIDTH-1:0] mem [MEM_DEPTH];   // program storage, no reset

   // write port, owned by the loader
   always_ff @(posedge i_clock) begin
      if (i_wr_en) begin
         mem[i_wr_addr] <= i_wr_data;
      end
   end

   // read port, owned by fetch; data valid the cycle after i_rd_en
   always_ff @(posedge i_clock) begin
      if (i_rd_en) begin
         o_rd_data <= mem[i_rd_addr];
      end
   end

endmodule

// File: verilog/program_loader.sv
`timescale 1ns/1ps

module program_loader
   (
      input  logic                          i_clock,
      input  logic                          i_soft_reset,
      input  logic                          i_run,

      input  logic                          i_load_req,
      input  logic [if_pkg::INSTR_WIDTH-1:0] i_load_word,
      output logic                          o_load_ack,

      output logic                          o_wr_en,
      output logic [if_pkg::ADDR_WIDTH-1:0]  o_wr_addr,
      output logic [if_pkg::INSTR_WIDTH-1:0] o_wr_data
   );

   import if_pkg::*;

   typedef enum logic {
      LD_IDLE,
      LD_ACKED
   } ld_state_t;

   ld_state_t             state;
   logic [ADDR_WIDTH-1:0] wr_addr;         // next free program address
   logic                  accept;

   // a word is taken only while the core is halted
   assign accept = (state == LD_IDLE) && i_load_req && !i_run;

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         state   <= LD_IDLE;
         wr_addr <= '0;
      end
      else begin
         case (state)
            LD_IDLE: begin
               if (accept) begin
                  state   <= LD_ACKED;
                  wr_addr <= wr_addr + 1'b1;   // step once per accepted word
               end
            end
            LD_ACKED: begin
               if (!i_load_req) begin
                  state <= LD_IDLE;            // req dropped, release ack
               end
            end
            default: state <= LD_IDLE;
         endcase
      end
   end

   assign o_load_ack = (state == LD_ACKED);

   // write lands on the same edge that raises ack
   assign o_wr_en   = accept;
   assign o_wr_addr = wr_addr;
   assign o_wr_data = i_load_word;

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
   (
      input  logic                          i_clock,
      input  logic                          i_soft_reset,
      input  logic                          i_run,

      input  logic                          i_branch_valid,
      input  logic [if_pkg::ADDR_WIDTH-1:0]  i_branch_target,

      input  logic [if_pkg::COUNT_WIDTH-1:0] i_free_slots,

      input  logic [if_pkg::INSTR_WIDTH-1:0] i_rd_data,
      output logic                          o_rd_en,
      output logic [if_pkg::ADDR_WIDTH-1:0]  o_rd_addr,

      output logic                          o_push,
      output if_pkg::fetch_word_t           o_push_word,
      output logic                          o_flush
   );

   import if_pkg::*;

   logic [ADDR_WIDTH-1:0] pc;
   logic                  inflight_valid;  // a read was issued last cycle
   logic [ADDR_WIDTH-1:0] inflight_pc;     // address tag of that read
   logic                  room;

   // two free slots leave space for this read even if the word in flight
   // is pushed in the same cycle
   assign room = (i_free_slots >= COUNT_WIDTH'(2));

   // no read in the branch cycle, the target is read next cycle
   assign o_rd_en   = i_run && room && !i_branch_valid;
   assign o_rd_addr = pc;

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         pc             <= '0;
         inflight_valid <= 1'b0;
      end
      else begin
         if (i_branch_valid) begin
            pc <= i_branch_target;
         end
         else if (o_rd_en) begin
            pc <= pc + 1'b1;
         end
         inflight_valid <= o_rd_en;
      end
   end

   always_ff @(posedge i_clock) begin
      if (o_rd_en) begin
         inflight_pc <= pc;
      end
   end

   // memory data arrives one cycle after the read, push it with its tag
   assign o_push = inflight_valid && !i_branch_valid;   // squash on branch

   always_comb begin
      o_push_word.pc    = inflight_pc;
      o_push_word.instr = i_rd_data;
   end

   // a redirect empties everything fetched down the old path
   assign o_flush = i_branch_valid;

endmodule

// File: verilog/instr_queue.sv
`timescale 1ns/1ps

module instr_queue
   (
      input  logic                          i_clock,
      input  logic                          i_soft_reset,
      input  logic                          i_flush,

      input  logic                          i_push,
      input  if_pkg::fetch_word_t           i_push_word,

      input  logic                          i_pop,
      output if_pkg::fetch_word_t           o_head,

      output logic                          o_empty,
      output logic [if_pkg::COUNT_WIDTH-1:0] o_free_slots
   );

   import if_pkg::*;

   fetch_word_t                      entries [QUEUE_DEPTH];
   logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(QUEUE_DEPTH)-1:0]   rd_ptr;
   logic [COUNT_WIDTH-1:0]           count;   // entries held
   logic                             full;
   logic                             do_push;
   logic                             do_pop;

   assign full    = (count == COUNT_WIDTH'(QUEUE_DEPTH));
   assign o_empty = (count == '0);

   assign do_push = i_push && !full;
   assign do_pop  = i_pop && !o_empty;

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset || i_flush) begin
         wr_ptr <= '0;                  // flush wins over push and pop
         rd_ptr <= '0;
         count  <= '0;
      end
      else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge i_clock) begin
      if (do_push && !i_flush) begin
         entries[wr_ptr] <= i_push_word;
      end
   end

   assign o_head       = entries[rd_ptr];
   assign o_free_slots = COUNT_WIDTH'(QUEUE_DEPTH) - count;

endmodule

// File: verilog/instr_issue.sv
`timescale 1ns/1ps

module instr_issue
   (
      input  logic                i_clock,
      input  logic                i_soft_reset,
      input  logic                i_flush,

      input  logic                i_empty,
      input  if_pkg::fetch_word_t i_head,
      output logic                o_pop,

      input  logic                i_issue_ack,
      output logic                o_issue_req,
      output if_pkg::fetch_word_t o_issue_word
   );

   import if_pkg::*;

   typedef enum logic [1:0] {
      IS_LOAD,
      IS_OFFER,
      IS_WAIT_LOW
   } is_state_t;

   is_state_t   state;
   fetch_word_t hold;                      // word presented on the port

   assign o_pop = (state == IS_LOAD) && !i_empty;

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         state <= IS_LOAD;
      end
      else begin
         case (state)
            IS_LOAD: begin
               // a word popped under flush is from the old path, drop it
               if (o_pop && !i_flush) begin
                  state <= IS_OFFER;
               end
            end
            IS_OFFER: begin
               if (i_issue_ack) begin
                  state <= IS_WAIT_LOW;   // req falls
               end
            end
            IS_WAIT_LOW: begin
               if (!i_issue_ack) begin
                  state <= IS_LOAD;       // handshake closed
               end
            end
            default: state <= IS_LOAD;
         endcase
      end
   end

   // word stays put from pop until the handshake closes
   always_ff @(posedge i_clock) begin
      if (o_pop) begin
         hold <= i_head;
      end
   end

   assign o_issue_req  = (state == IS_OFFER);
   assign o_issue_word = hold;

endmodule

// File: verilog/if_stage_top.sv
`timescale 1ns/1ps

module if_stage_top
   (
      input  logic                          i_clock,
      input  logic                          i_soft_reset,
      input  logic                          i_run,

      input  logic                          i_load_req,
      input  logic [if_pkg::INSTR_WIDTH-1:0] i_load_word,
      output logic                          o_load_ack,

      input  logic                          i_branch_valid,
      input  logic [if_pkg::ADDR_WIDTH-1:0]  i_branch_target,

      input  logic                          i_issue_ack,
      output logic                          o_issue_req,
      output if_pkg::fetch_word_t           o_issue_word
   );

   import if_pkg::*;

   // loader to memory
   logic                   mem_wr_en;
   logic [ADDR_WIDTH-1:0]  mem_wr_addr;
   logic [INSTR_WIDTH-1:0] mem_wr_data;

   // fetch to memory
   logic                   mem_rd_en;
   logic [ADDR_WIDTH-1:0]  mem_rd_addr;
   logic [INSTR_WIDTH-1:0] mem_rd_data;

   // queue links
   logic                   q_push;
   fetch_word_t            q_push_word;
   logic                   q_flush;
   logic                   q_pop;
   fetch_word_t            q_head;
   logic                   q_empty;
   logic [COUNT_WIDTH-1:0] q_free_slots;

   program_loader u_program_loader (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_run        (i_run),
      .i_load_req   (i_load_req),
      .i_load_word  (i_load_word),
      .o_load_ack   (o_load_ack),
      .o_wr_en      (mem_wr_en),
      .o_wr_addr    (mem_wr_addr),
      .o_wr_data    (mem_wr_data)
   );

   program_memory u_program_memory (
      .i_clock   (i_clock),
      .i_wr_en   (mem_wr_en),
      .i_wr_addr (mem_wr_addr),
      .i_wr_data (mem_wr_data),
      .i_rd_en   (mem_rd_en),
      .i_rd_addr (mem_rd_addr),
      .o_rd_data (mem_rd_data)
   );

   fetch_unit u_fetch_unit (
      .i_clock         (i_clock),
      .i_soft_reset    (i_soft_reset),
      .i_run           (i_run),
      .i_branch_valid  (i_branch_valid),
      .i_branch_target (i_branch_target),
      .i_free_slots    (q_free_slots),
      .i_rd_data       (mem_rd_data),
      .o_rd_en         (mem_rd_en),
      .o_rd_addr       (mem_rd_addr),
      .o_push          (q_push),
      .o_push_word     (q_push_word),
      .o_flush         (q_flush)
   );

   instr_queue u_instr_queue (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_flush      (q_flush),
      .i_push       (q_push),
      .i_push_word  (q_push_word),
      .i_pop        (q_pop),
      .o_head       (q_head),
      .o_empty      (q_empty),
      .o_free_slots (q_free_slots)
   );

   instr_issue u_instr_issue (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_flush      (q_flush),
      .i_empty      (q_empty),
      .i_head       (q_head),
      .o_pop        (q_pop),
      .i_issue_ack  (i_issue_ack),
      .o_issue_req  (o_issue_req),
      .o_issue_word (o_issue_word)
   );

endmodule

// File: dv/if_stage_properties.sv
`timescale 1ns/1ps

module if_stage_properties
   (
      input logic                           i_clock,
      input logic                           i_soft_reset,
      input logic                           i_req,
      input logic                           i_ack,
      input if_pkg::fetch_word_t            i_word,
      input logic                           i_push,
      input logic [if_pkg::COUNT_WIDTH-1:0] i_free_slots
   );

   import if_pkg::*;

   // initiator holds req until the responder answers
   req_held: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      (i_req && !i_ack) |=> (i_req || i_ack))
      else $error("req fell before ack rose");

   word_stable: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      (i_req && !i_ack) |=> $stable(i_word))
      else $error("word changed while req was high");

   // the loader acks on the edge after req, so req may already be gone
   ack_needs_req: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      $rose(i_ack) |-> (i_req || $past(i_req)))
      else $error("ack rose without req");

   push_has_room: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      i_push |-> (i_free_slots != '0))
      else $error("push into a full queue");

endmodule

bind instr_issue if_stage_properties u_issue_props (
   .i_clock      (i_clock),
   .i_soft_reset (i_soft_reset),
   .i_req        (o_issue_req),
   .i_ack        (i_issue_ack),
   .i_word       (o_issue_word),
   .i_push       (1'b0),
   .i_free_slots ('0)
);

bind program_loader if_stage_properties u_load_props (
   .i_clock      (i_clock),
   .i_soft_reset (i_soft_reset),
   .i_req        (i_load_req),
   .i_ack        (o_load_ack),
   .i_word       ({{if_pkg::ADDR_WIDTH{1'b0}}, i_load_word}),
   .i_push       (1'b0),
   .i_free_slots ('0)
);

bind instr_queue if_stage_properties u_queue_props (
   .i_clock      (i_clock),
   .i_soft_reset (i_soft_reset),
   .i_req        (1'b0),
   .i_ack        (1'b0),
   .i_word       ('0),
   .i_push       (i_push),
   .i_free_slots (o_free_slots)
);

// File: dv/if_stage_tb.sv
`timescale 1ns/1ps

module if_stage_tb;

   import if_pkg::*;

   localparam int TIMEOUT    = 200;       // cycles allowed for any one wait
   localparam int LOAD_COUNT = 64;
   localparam logic [ADDR_WIDTH-1:0] BRANCH_ADDR = 11'd40;

   logic                   clock;
   logic                   soft_reset;
   logic                   run;
   logic                   load_req;
   logic [INSTR_WIDTH-1:0] load_word;
   logic                   load_ack;
   logic                   branch_valid;
   logic [ADDR_WIDTH-1:0]  branch_target;
   logic                   issue_ack;
   logic                   issue_req;
   fetch_word_t            issue_word;

   logic [INSTR_WIDTH-1:0] model [MEM_DEPTH];   // expected program contents
   logic [ADDR_WIDTH-1:0]  load_addr;           // next address the loader fills
   logic [ADDR_WIDTH-1:0]  next_pc;             // next pc expected on the issue port
   logic [31:0]            rng_state;
   int                     checks;
   int                     errors;
   int                     timeouts;

   if_stage_top u_dut (
      .i_clock         (clock),
      .i_soft_reset    (soft_reset),
      .i_run           (run),
      .i_load_req      (load_req),
      .i_load_word     (load_word),
      .o_load_ack      (load_ack),
      .i_branch_valid  (branch_valid),
      .i_branch_target (branch_target),
      .i_issue_ack     (issue_ack),
      .o_issue_req     (issue_req),
      .o_issue_word    (issue_word)
   );

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic report_mismatch(input string msg);
      errors++;
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("timed out at %0t ns waiting for %s", $time, what);
   endtask

   // full four-phase load, ack must rise and then fall again
   task automatic load_one(input logic [INSTR_WIDTH-1:0] word);
      int n;
      load_word = word;
      load_req  = 1'b1;
      n = 0;
      while (!load_ack && n < TIMEOUT) begin
         @(negedge clock);
         n++;
      end
      checks++;
      if (!load_ack) report_timeout("load ack to rise");
      load_req = 1'b0;
      n = 0;
      while (load_ack && n < TIMEOUT) begin
         @(negedge clock);
         n++;
      end
      if (load_ack) report_timeout("load ack to fall");
      model[load_addr] = word;
      load_addr++;
   endtask

   task automatic receive_word(input int ack_delay, output fetch_word_t w);
      int n;
      n = 0;
      while (!issue_req && n < TIMEOUT) begin
         @(negedge clock);
         n++;
      end
      if (!issue_req) report_timeout("issue req to rise");
      w = issue_word;
      repeat (ack_delay) @(negedge clock);   // stall the consumer
      issue_ack = 1'b1;
      n = 0;
      while (issue_req && n < TIMEOUT) begin
         @(negedge clock);
         n++;
      end
      if (issue_req) report_timeout("issue req to fall");
      issue_ack = 1'b0;
   endtask

   task automatic check_word(input fetch_word_t w);
      checks++;
      if (w.pc != next_pc) begin
         report_mismatch($sformatf("pc %0d, expected %0d", w.pc, next_pc));
      end
      else if (w.instr !== model[next_pc]) begin
         report_mismatch($sformatf("pc %0d instr %h, expected %h",
                                   w.pc, w.instr, model[next_pc]));
      end
      next_pc++;
   endtask

   task automatic receive_run(input int count, input int ack_delay);
      fetch_word_t w;
      int          i;
      for (i = 0; i < count; i++) begin
         receive_word(ack_delay, w);
         check_word(w);
      end
   endtask

   // redirect while a word sits on the port, one old word may still finish
   task automatic branch_check(input logic [ADDR_WIDTH-1:0] target, input int count);
      fetch_word_t w;
      int          n;
      n = 0;
      while (!issue_req && n < TIMEOUT) begin
         @(negedge clock);
         n++;
      end
      if (!issue_req) report_timeout("a word on the issue port before the branch");
      branch_valid  = 1'b1;
      branch_target = target;
      @(negedge clock);
      branch_valid  = 1'b0;
      next_pc = target;
      receive_word(0, w);
      if (w.pc != target) begin
         checks++;
         if (w.instr !== model[w.pc]) begin
            report_mismatch($sformatf("old-path word pc %0d carries wrong instr", w.pc));
         end
         receive_word(0, w);
      end
      check_word(w);
      receive_run(count - 1, 0);
   endtask

   task automatic test_load;
      int i;
      checks++;
      if (load_ack || issue_req) report_mismatch("handshake outputs high after reset");
      for (i = 0; i < LOAD_COUNT; i++) begin
         rng_state = xorshift32(rng_state);
         load_one(rng_state);
      end
   endtask

   task automatic test_run_in_order;
      run     = 1'b1;
      next_pc = '0;
      receive_run(16, 0);
   endtask

   task automatic test_back_pressure;
      receive_run(4, 30);            // long stalls fill the queue
      receive_run(12, 1);
   endtask

   task automatic test_branch;
      receive_run(2, 0);
      branch_check(BRANCH_ADDR, 16);
   endtask

   task automatic test_load_while_running;
      int i;
      rng_state = xorshift32(rng_state);
      load_word = rng_state;
      load_req  = 1'b1;
      for (i = 0; i < 30; i++) begin
         @(negedge clock);
         checks++;
         if (load_ack) report_mismatch("load acked while running");
      end
      run = 1'b0;
      load_one(rng_state);           // same word, now accepted at load_addr
      run = 1'b1;
      branch_check(load_addr - 1'b1, 1);
      run = 1'b0;
   endtask

   initial begin
      rng_state     = 32'd23165;
      soft_reset    = 1'b0;
      run           = 1'b0;
      load_req      = 1'b0;
      load_word     = '0;
      branch_valid  = 1'b0;
      branch_target = '0;
      issue_ack     = 1'b0;
      load_addr     = '0;
      next_pc       = '0;
      checks        = 0;
      errors        = 0;
      timeouts      = 0;
      repeat (2) @(negedge clock);
      soft_reset = 1'b1;
      @(negedge clock);
      test_load();
      test_run_in_order();
      test_back_pressure();
      test_branch();
      test_load_while_running();
      repeat (5) @(negedge clock);
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Finished with no errors");
      end
      else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: if_stage_top.f
verilog/if_pkg.sv
verilog/program_memory.sv
verilog/program_loader.sv
verilog/fetch_unit.sv
verilog/instr_queue.sv
verilog/instr_issue.sv
verilog/if_stage_top.sv
dv/if_stage_properties.sv
dv/if_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module if_stage_tb \
   -f if_stage_top.f \
   -o if_stage_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

output=$(./obj_dir/if_stage_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "Finished with no errors"; then
   exit 0
fi
exit 1
